// ==== src/snes_bus_pkg.sv ====
package snes_bus_pkg;

	// number of coprocessor mappers without the base LoROM/HiROM/DSP mapper
	localparam int MAP_COUNT = 7;

	// upper nibble of the cartridge type for a plain cartridge
	localparam logic [3:0] SS_BASIC_FAMILY = 4'h0;

	typedef logic [7:0]           cpu_data_t;
	typedef logic [23:0]          rom_addr_t;
	typedef logic [15:0]          rom_data_t;
	typedef logic [19:0]          bsram_addr_t;
	typedef logic [15:0]          aram_addr_t;
	typedef logic [MAP_COUNT-1:0] map_active_t;
	typedef logic [7:0]           rom_type_t;

	// value i selects the mapper behind map_active bit i-1
	typedef enum logic [2:0] {
		MAP_DLH     = 3'd0,
		MAP_CX4     = 3'd1,
		MAP_SDD1    = 3'd2,
		MAP_GSU     = 3'd3,
		MAP_SA1     = 3'd4,
		MAP_SPC7110 = 3'd5,
		MAP_BSX     = 3'd6,
		MAP_SUFAMI  = 3'd7
	} map_sel_e;

	// everything a mapper drives towards the cartridge side
	typedef struct packed {
		cpu_data_t   data;
		logic        irq_n;
		rom_addr_t   rom_addr;
		cpu_data_t   rom_d;
		logic        rom_ce_n;
		logic        rom_oe_n;
		logic        rom_we_n;
		logic        rom_word;
		bsram_addr_t bsram_addr;
		cpu_data_t   bsram_d;
		logic        bsram_ce_n;
		logic        bsram_oe_n;
		logic        bsram_we_n;
	} mapper_bus_t;

	typedef mapper_bus_t [MAP_COUNT:0] mapper_array_t;

	typedef struct packed {
		rom_addr_t addr;
		rom_data_t d;
		logic      ce_n;
		logic      oe_n;
		logic      we_n;
		logic      word;
	} rom_bus_t;

	typedef struct packed {
		bsram_addr_t addr;
		cpu_data_t   d;
		logic        ce_n;
		logic        oe_n;
		logic        we_n;
	} bsram_bus_t;

	typedef struct packed {
		aram_addr_t addr;
		cpu_data_t  d;
		logic       ce_n;
		logic       oe_n;
		logic       we_n;
	} aram_bus_t;

	typedef struct packed {
		logic do_ovr;
		logic rom_ovr;
		logic aram_sel;
		logic bsram_sel;
		logic busy;
	} ss_ctrl_t;

endpackage

// ==== src/map_select.sv ====
`timescale 1ns/1ps

module map_select (
	input  logic                       mclk,
	input  logic                       rst_n,
	input  snes_bus_pkg::map_active_t  map_active,
	input  snes_bus_pkg::rom_type_t    rom_type,
	input  logic                       ss_busy,
	output snes_bus_pkg::map_sel_e     map_sel,
	output logic                       gsu_active,
	output logic                       ss_avail,
	output logic                       turbo_allow
);

	snes_bus_pkg::map_sel_e sel_next;
	snes_bus_pkg::map_sel_e sel_q;
	logic                   basic_cart;

	// anything that is not exactly one flag falls back to the base mapper
	always_comb begin
		case (map_active)
			7'b0000001: sel_next = snes_bus_pkg::MAP_CX4;
			7'b0000010: sel_next = snes_bus_pkg::MAP_SDD1;
			7'b0000100: sel_next = snes_bus_pkg::MAP_GSU;
			7'b0001000: sel_next = snes_bus_pkg::MAP_SA1;
			7'b0010000: sel_next = snes_bus_pkg::MAP_SPC7110;
			7'b0100000: sel_next = snes_bus_pkg::MAP_BSX;
			7'b1000000: sel_next = snes_bus_pkg::MAP_SUFAMI;
			default:    sel_next = snes_bus_pkg::MAP_DLH;
		endcase
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= snes_bus_pkg::MAP_DLH;
		end else begin
			sel_q <= sel_next;
		end
	end

	assign map_sel = sel_q;

	assign basic_cart = (rom_type[7:4] == snes_bus_pkg::SS_BASIC_FAMILY);

	// savestates work on plain carts and on SA-1 because the other chips keep hidden state
	assign ss_avail = basic_cart | (sel_q == snes_bus_pkg::MAP_SA1);

	// SA-1 and S-DD1 timing breaks when the CPU runs fast
	assign turbo_allow = ~((sel_q == snes_bus_pkg::MAP_SA1) |
		(sel_q == snes_bus_pkg::MAP_SDD1) | ss_busy);

	assign gsu_active = (sel_q == snes_bus_pkg::MAP_GSU);

	// activity flags come from the cartridge header, so two chips never claim the bus
	a_map_active_onehot: assert property (
		@(posedge mclk) disable iff (!rst_n)
		$onehot0(map_active)
	);

endmodule

// ==== src/mapper_bus_mux.sv ====
`timescale 1ns/1ps

module mapper_bus_mux (
	input  logic                        mclk,
	input  logic                        rst_n,
	input  snes_bus_pkg::map_sel_e      map_sel,
	input  snes_bus_pkg::mapper_array_t mappers,
	output snes_bus_pkg::cpu_data_t     cart_data,
	output logic                        irq_n,
	output snes_bus_pkg::rom_bus_t      base_rom,
	output snes_bus_pkg::bsram_bus_t    base_bsram
);

	localparam int ROM_A_MSB = $bits(snes_bus_pkg::rom_addr_t) - 1;

	snes_bus_pkg::mapper_bus_t sel;
	logic                      is_dlh;
	logic                      is_bsx;

	assign sel    = mappers[map_sel];
	assign is_dlh = (map_sel == snes_bus_pkg::MAP_DLH);
	assign is_bsx = (map_sel == snes_bus_pkg::MAP_BSX);

	assign cart_data = sel.data;
	assign irq_n     = sel.irq_n;

	always_comb begin
		base_rom.addr = sel.rom_addr;
		// coprocessor mappers only address the lower 8 MB
		if (!is_dlh) begin
			base_rom.addr[ROM_A_MSB] = 1'b0;
		end
		base_rom.ce_n = sel.rom_ce_n;
		base_rom.oe_n = sel.rom_oe_n;
		base_rom.word = sel.rom_word;

		// BS-X flash is the only writable ROM space
		if (is_bsx) begin
			base_rom.d    = {8'h00, sel.rom_d};
			base_rom.we_n = sel.rom_we_n;
		end else begin
			base_rom.d    = '0;
			base_rom.we_n = 1'b1;
		end
	end

	always_comb begin
		base_bsram.addr = sel.bsram_addr;
		base_bsram.d    = sel.bsram_d;
		base_bsram.ce_n = sel.bsram_ce_n;
		base_bsram.oe_n = sel.bsram_oe_n;
		base_bsram.we_n = sel.bsram_we_n;
	end

	a_rom_write_bsx_only: assert property (
		@(posedge mclk) disable iff (!rst_n)
		(map_sel != snes_bus_pkg::MAP_BSX) |-> (base_rom.we_n && base_rom.d == '0)
	);

endmodule

// ==== src/cart_bus_override.sv ====
`timescale 1ns/1ps

module cart_bus_override (
	input  logic                      mclk,
	input  logic                      rst_n,
	input  snes_bus_pkg::cpu_data_t   cart_data,
	input  snes_bus_pkg::rom_bus_t    base_rom,
	input  snes_bus_pkg::bsram_bus_t  base_bsram,
	input  snes_bus_pkg::aram_bus_t   snes_aram,
	input  logic                      msu_sel,
	input  snes_bus_pkg::cpu_data_t   msu_do,
	input  snes_bus_pkg::ss_ctrl_t    ss_ctrl,
	input  snes_bus_pkg::cpu_data_t   ss_do,
	input  snes_bus_pkg::bsram_addr_t ss_ext_addr,
	input  snes_bus_pkg::rom_addr_t   ss_rom_addr,
	input  logic                      pard_n,
	input  logic                      pawr_n,
	output snes_bus_pkg::cpu_data_t   di,
	output snes_bus_pkg::rom_bus_t    rom,
	output snes_bus_pkg::bsram_bus_t  bsram,
	output snes_bus_pkg::aram_bus_t   aram
);

	// savestate engine wins over MSU, MSU wins over the cartridge
	always_comb begin
		if (ss_ctrl.do_ovr) begin
			di = ss_do;
		end else if (msu_sel) begin
			di = msu_do;
		end else begin
			di = cart_data;
		end
	end

	always_comb begin
		rom = base_rom;
		if (ss_ctrl.rom_ovr) begin
			rom.addr = ss_rom_addr;
		end
	end

	// during a save or load the engine drives audio RAM through the B-bus strobes
	always_comb begin
		if (ss_ctrl.aram_sel) begin
			aram.addr = snes_bus_pkg::aram_addr_t'(ss_ext_addr);
			aram.d    = ss_do;
			aram.ce_n = 1'b0;
			aram.oe_n = pard_n;
			aram.we_n = pawr_n;
		end else begin
			aram = snes_aram;
		end
	end

	always_comb begin
		if (ss_ctrl.bsram_sel) begin
			bsram.addr = ss_ext_addr;
			bsram.d    = ss_do;
			bsram.ce_n = 1'b0;
			bsram.oe_n = pard_n;
			bsram.we_n = pawr_n;
		end else begin
			bsram = base_bsram;
		end
	end

	a_aram_takeover: assert property (
		@(posedge mclk) disable iff (!rst_n)
		ss_ctrl.aram_sel |-> !aram.ce_n
	);

	a_bsram_takeover: assert property (
		@(posedge mclk) disable iff (!rst_n)
		ss_ctrl.bsram_sel |-> !bsram.ce_n
	);

endmodule

// ==== src/snes_cart_bus.sv ====
`timescale 1ns/1ps

module snes_cart_bus (
	input  logic                        mclk,
	input  logic                        rst_n,
	input  snes_bus_pkg::map_active_t   map_active,
	input  snes_bus_pkg::rom_type_t     rom_type,
	input  snes_bus_pkg::mapper_array_t mappers,
	input  logic                        msu_sel,
	input  snes_bus_pkg::cpu_data_t     msu_do,
	input  snes_bus_pkg::aram_bus_t     snes_aram,
	input  logic                        pard_n,
	input  logic                        pawr_n,
	input  snes_bus_pkg::ss_ctrl_t      ss_ctrl,
	input  snes_bus_pkg::cpu_data_t     ss_do,
	input  snes_bus_pkg::bsram_addr_t   ss_ext_addr,
	input  snes_bus_pkg::rom_addr_t     ss_rom_addr,
	output snes_bus_pkg::cpu_data_t     di,
	output logic                        irq_n,
	output snes_bus_pkg::rom_bus_t      rom,
	output snes_bus_pkg::bsram_bus_t    bsram,
	output snes_bus_pkg::aram_bus_t     aram,
	output logic                        ss_avail,
	output logic                        turbo_allow,
	output logic                        gsu_active
);

	snes_bus_pkg::map_sel_e   map_sel;
	snes_bus_pkg::cpu_data_t  cart_data;
	snes_bus_pkg::rom_bus_t   base_rom;
	snes_bus_pkg::bsram_bus_t base_bsram;

	map_select map_select0 (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.map_active  (map_active),
		.rom_type    (rom_type),
		.ss_busy     (ss_ctrl.busy),
		.map_sel     (map_sel),
		.gsu_active  (gsu_active),
		.ss_avail    (ss_avail),
		.turbo_allow (turbo_allow)
	);

	mapper_bus_mux mapper_bus_mux0 (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.map_sel    (map_sel),
		.mappers    (mappers),
		.cart_data  (cart_data),
		.irq_n      (irq_n),
		.base_rom   (base_rom),
		.base_bsram (base_bsram)
	);

	cart_bus_override cart_bus_override0 (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.cart_data   (cart_data),
		.base_rom    (base_rom),
		.base_bsram  (base_bsram),
		.snes_aram   (snes_aram),
		.msu_sel     (msu_sel),
		.msu_do      (msu_do),
		.ss_ctrl     (ss_ctrl),
		.ss_do       (ss_do),
		.ss_ext_addr (ss_ext_addr),
		.ss_rom_addr (ss_rom_addr),
		.pard_n      (pard_n),
		.pawr_n      (pawr_n),
		.di          (di),
		.rom         (rom),
		.bsram       (bsram),
		.aram        (aram)
	);

endmodule

// ==== testbench/tb_snes_cart_bus.sv ====
`timescale 1ns/1ps

module tb_snes_cart_bus;

	logic                        mclk;
	logic                        rst_n;
	snes_bus_pkg::map_active_t   map_active;
	snes_bus_pkg::rom_type_t     rom_type;
	snes_bus_pkg::mapper_array_t mappers;
	logic                        msu_sel;
	snes_bus_pkg::cpu_data_t     msu_do;
	snes_bus_pkg::aram_bus_t     snes_aram;
	logic                        pard_n;
	logic                        pawr_n;
	snes_bus_pkg::ss_ctrl_t      ss_ctrl;
	snes_bus_pkg::cpu_data_t     ss_do;
	snes_bus_pkg::bsram_addr_t   ss_ext_addr;
	snes_bus_pkg::rom_addr_t     ss_rom_addr;

	snes_bus_pkg::cpu_data_t     di;
	logic                        irq_n;
	snes_bus_pkg::rom_bus_t      rom;
	snes_bus_pkg::bsram_bus_t    bsram;
	snes_bus_pkg::aram_bus_t     aram;
	logic                        ss_avail;
	logic                        turbo_allow;
	logic                        gsu_active;

	// the reference selection lags map_active by one edge
	snes_bus_pkg::map_active_t   act_q;
	logic [2:0]                  exp_sel;
	snes_bus_pkg::mapper_bus_t   exp_m;
	snes_bus_pkg::cpu_data_t     exp_di;
	snes_bus_pkg::rom_bus_t      exp_rom;
	snes_bus_pkg::bsram_bus_t    exp_bsram;
	snes_bus_pkg::aram_bus_t     exp_aram;
	logic                        exp_ss_avail;
	logic                        exp_turbo;
	logic                        exp_gsu;
	logic [31:0]                 lcg_state;

	snes_cart_bus dut0 (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.map_active  (map_active),
		.rom_type    (rom_type),
		.mappers     (mappers),
		.msu_sel     (msu_sel),
		.msu_do      (msu_do),
		.snes_aram   (snes_aram),
		.pard_n      (pard_n),
		.pawr_n      (pawr_n),
		.ss_ctrl     (ss_ctrl),
		.ss_do       (ss_do),
		.ss_ext_addr (ss_ext_addr),
		.ss_rom_addr (ss_rom_addr),
		.di          (di),
		.irq_n       (irq_n),
		.rom         (rom),
		.bsram       (bsram),
		.aram        (aram),
		.ss_avail    (ss_avail),
		.turbo_allow (turbo_allow),
		.gsu_active  (gsu_active)
	);

	initial begin
		mclk = 1'b0;
		forever #2 mclk = ~mclk;
	end

	// the low LCG bits repeat quickly, so only the upper halves are used
	function automatic logic [31:0] rand32();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		hi = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {hi, lcg_state[31:16]};
	endfunction

	// exactly one flag names a coprocessor, anything else means the base mapper
	function automatic logic [2:0] sel_from_flags(input snes_bus_pkg::map_active_t act);
		logic [2:0] sel;
		int         ones;
		sel = 3'd0;
		ones = 0;
		for (int i = 0; i < snes_bus_pkg::MAP_COUNT; i++) begin
			if (act[i]) begin
				ones++;
				sel = 3'(i + 1);
			end
		end
		if (ones != 1) begin
			sel = 3'd0;
		end
		return sel;
	endfunction

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			act_q <= '0;
		end else begin
			act_q <= map_active;
		end
	end

	always_comb begin
		exp_sel = sel_from_flags(act_q);
		exp_m = mappers[exp_sel];

		if (ss_ctrl.do_ovr) begin
			exp_di = ss_do;
		end else if (msu_sel) begin
			exp_di = msu_do;
		end else begin
			exp_di = exp_m.data;
		end

		exp_rom.addr = exp_m.rom_addr;
		if (exp_sel != 3'd0) begin
			exp_rom.addr = {1'b0, exp_m.rom_addr[22:0]};
		end
		if (ss_ctrl.rom_ovr) begin
			exp_rom.addr = ss_rom_addr;
		end
		exp_rom.ce_n = exp_m.rom_ce_n;
		exp_rom.oe_n = exp_m.rom_oe_n;
		exp_rom.word = exp_m.rom_word;
		if (exp_sel == snes_bus_pkg::MAP_BSX) begin
			exp_rom.d    = {8'h00, exp_m.rom_d};
			exp_rom.we_n = exp_m.rom_we_n;
		end else begin
			exp_rom.d    = 16'h0000;
			exp_rom.we_n = 1'b1;
		end

		if (ss_ctrl.bsram_sel) begin
			exp_bsram = {ss_ext_addr, ss_do, 1'b0, pard_n, pawr_n};
		end else begin
			exp_bsram = {exp_m.bsram_addr, exp_m.bsram_d, exp_m.bsram_ce_n,
				exp_m.bsram_oe_n, exp_m.bsram_we_n};
		end

		if (ss_ctrl.aram_sel) begin
			exp_aram = {ss_ext_addr[15:0], ss_do, 1'b0, pard_n, pawr_n};
		end else begin
			exp_aram = snes_aram;
		end

		exp_ss_avail = (rom_type[7:4] == snes_bus_pkg::SS_BASIC_FAMILY) ||
			(exp_sel == snes_bus_pkg::MAP_SA1);
		exp_turbo = !((exp_sel == snes_bus_pkg::MAP_SA1) ||
			(exp_sel == snes_bus_pkg::MAP_SDD1) || ss_ctrl.busy);
		exp_gsu = (exp_sel == snes_bus_pkg::MAP_GSU);
	end

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("[ERROR] t=%0t ns signal=%s expected=%0h actual=%0h",
			$time, name, expected, actual);
		$display("Simulation failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic fail_run(input string why);
		$display("Timeout at %0t ns: %s", $time, why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	a_di: assert property (@(posedge mclk) disable iff (!rst_n) di == exp_di)
		else report_mismatch("di", $sampled(exp_di), $sampled(di));
	a_irq_n: assert property (@(posedge mclk) disable iff (!rst_n) irq_n == exp_m.irq_n)
		else report_mismatch("irq_n", $sampled(exp_m.irq_n), $sampled(irq_n));
	a_rom: assert property (@(posedge mclk) disable iff (!rst_n) rom == exp_rom)
		else report_mismatch("rom", $sampled(exp_rom), $sampled(rom));
	a_bsram: assert property (@(posedge mclk) disable iff (!rst_n) bsram == exp_bsram)
		else report_mismatch("bsram", $sampled(exp_bsram), $sampled(bsram));
	a_aram: assert property (@(posedge mclk) disable iff (!rst_n) aram == exp_aram)
		else report_mismatch("aram", $sampled(exp_aram), $sampled(aram));
	a_ss_avail: assert property (@(posedge mclk) disable iff (!rst_n) ss_avail == exp_ss_avail)
		else report_mismatch("ss_avail", $sampled(exp_ss_avail), $sampled(ss_avail));
	a_turbo: assert property (@(posedge mclk) disable iff (!rst_n) turbo_allow == exp_turbo)
		else report_mismatch("turbo_allow", $sampled(exp_turbo), $sampled(turbo_allow));
	a_gsu: assert property (@(posedge mclk) disable iff (!rst_n) gsu_active == exp_gsu)
		else report_mismatch("gsu_active", $sampled(exp_gsu), $sampled(gsu_active));

	task automatic next_cycle();
		@(posedge mclk);
		#1;
	endtask

	task automatic select_mapper(input int idx);
		map_active = '0;
		if (idx > 0) begin
			map_active[idx-1] = 1'b1;
		end
	endtask

	task automatic fill_mappers();
		logic [95:0] raw;
		for (int i = 0; i <= snes_bus_pkg::MAP_COUNT; i++) begin
			raw = {rand32(), rand32(), rand32()};
			mappers[i] = raw[$bits(snes_bus_pkg::mapper_bus_t)-1:0];
			// keep the top ROM address bit set so clearing it is visible
			mappers[i].rom_addr[23] = 1'b1;
		end
	endtask

	task automatic fill_side_inputs(input logic overrides);
		logic [31:0] r;
		r = rand32();
		msu_do = r[7:0];
		ss_do = r[15:8];
		pard_n = r[16];
		pawr_n = r[17];
		rom_type = r[31:24];
		if (r[18]) begin
			rom_type[7:4] = snes_bus_pkg::SS_BASIC_FAMILY;
		end
		r = rand32();
		ss_ext_addr = r[19:0];
		ss_ctrl.busy = r[21];
		msu_sel = overrides & r[20];
		ss_ctrl.do_ovr = overrides & r[22];
		ss_ctrl.rom_ovr = overrides & r[23];
		ss_ctrl.aram_sel = overrides & r[24];
		ss_ctrl.bsram_sel = overrides & r[25];
		r = rand32();
		ss_rom_addr = r[23:0];
		r = rand32();
		snes_aram = r[26:0];
	endtask

	task automatic wait_gsu(input logic level);
		int waited;
		waited = 0;
		while (gsu_active !== level) begin
			if (waited == 8) begin
				fail_run("gsu_active did not follow the mapper selection");
			end else begin
				next_cycle();
				waited++;
			end
		end
	endtask

	task automatic run_random(input int cycles, input logic overrides);
		for (int i = 0; i < cycles; i++) begin
			fill_mappers();
			fill_side_inputs(overrides);
			next_cycle();
		end
	endtask

	initial begin
		logic [31:0] r;
		lcg_state = 32'h41ae;
		rst_n = 1'b0;
		select_mapper(0);
		fill_mappers();
		fill_side_inputs(1'b0);
		repeat (4) @(posedge mclk);
		#1;
		rst_n = 1'b1;

		// base mapper straight after reset
		run_random(8, 1'b0);
		wait_gsu(1'b0);

		for (int idx = 1; idx <= snes_bus_pkg::MAP_COUNT; idx++) begin
			select_mapper(idx);
			next_cycle();
			wait_gsu(idx == int'(snes_bus_pkg::MAP_GSU));
			run_random(6, 1'b0);
		end
		select_mapper(0);
		next_cycle();
		wait_gsu(1'b0);

		// read priority and savestate takeover under a changing selection
		for (int blk = 0; blk < 16; blk++) begin
			r = rand32();
			select_mapper(int'(r[2:0]));
			run_random(8, 1'b1);
		end

		for (int idx = 0; idx <= snes_bus_pkg::MAP_COUNT; idx++) begin
			select_mapper(idx);
			next_cycle();
			wait_gsu(idx == int'(snes_bus_pkg::MAP_GSU));
			run_random(8, 1'b1);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== flist.f ====
src/snes_bus_pkg.sv
src/map_select.sv
src/mapper_bus_mux.sv
src/cart_bus_override.sv
src/snes_cart_bus.sv
testbench/tb_snes_cart_bus.sv
